// File: hw/i2c_avl_pkg.sv
// shared widths and the byte type
// bus phase encoding of the slave fsm
package i2c_avl_pkg;

    localparam int AVL_ADDR_W = 32;
    localparam int AVL_DATA_W = 32;
    localparam int BYTE_W     = 8;
    localparam int LANES      = 4;

    // byte lane select bits in an avalon word
    localparam int LANE_W     = $clog2(LANES);

    // nine bit slots per byte, data plus ack
    localparam int BIT_CNT_W  = 4;

    typedef logic [BYTE_W-1:0] byte_t;

    typedef enum logic [2:0] {
        IDLE,
        DEV_ADDR,     // first byte after start
        REG_ADDR,     // pointer bytes, msb first
        WR_DATA,
        RD_DATA,
        IGNORE        // not addressed until the next start
    } bus_phase_e;

endpackage

// File: hw/i2c_line_if.sv
// filtered i2c line levels and bus events
// shared by the front stages and the byte shifter
`timescale 1ns/1ps

interface i2c_line_if;

    logic sda;
    logic scl;
    logic scl_rise;   // one cycle pulses
    logic scl_fall;
    logic start_det;
    logic stop_det;

    modport filt (
        output sda,
        output scl
    );

    modport det (
        input  sda,
        input  scl,
        output scl_rise,
        output scl_fall,
        output start_det,
        output stop_det
    );

    modport user (
        input sda,
        input scl,
        input scl_rise,
        input scl_fall,
        input start_det,
        input stop_det
    );

endinterface

// File: hw/i2c_byte_if.sv
// byte level handshake between the shifter and the slave fsm
`timescale 1ns/1ps

interface i2c_byte_if;
    import i2c_avl_pkg::*;

    byte_t rx_byte;
    logic  byte_done;    // bit 8 rise in rx, bit 9 rise in tx
    logic  ack_en;
    byte_t tx_byte;
    logic  tx_mode;
    logic  master_ack;   // high when the master pulled sda low
    logic  hold;         // avalon access outstanding

    modport shifter (
        output rx_byte,
        output byte_done,
        output master_ack,
        input  ack_en,
        input  tx_byte,
        input  tx_mode,
        input  hold
    );

    modport ctrl (
        input  rx_byte,
        input  byte_done,
        input  master_ack,
        output ack_en,
        output tx_byte,
        output tx_mode,
        output hold
    );

endinterface

// File: hw/i2c_spike_filter.sv
// two flop synchronisers and spike suppression on sda and scl
`timescale 1ns/1ps

module i2c_spike_filter #(
    parameter int SPIKE_LEN = 2
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  i2c_data_in,
    input  logic  i2c_clk_in,
    i2c_line_if.filt line
);

    localparam int CNT_W = $clog2(SPIKE_LEN + 1);

    logic [1:0]       raw;      // bit 0 sda, bit 1 scl
    logic [1:0]       sync1;
    logic [1:0]       sync2;
    logic [1:0]       level;
    logic [CNT_W-1:0] cnt [2];

    assign raw = {i2c_clk_in, i2c_data_in};

    always_ff @(posedge clk) begin
        if (rst) begin
            sync1 <= '1;
            sync2 <= '1;
            level <= '1;   // idle bus is high
            cnt[0] <= '0;
            cnt[1] <= '0;
        end else begin
            sync1 <= raw;
            sync2 <= sync1;
            for (int i = 0; i < 2; i++) begin
                if (sync2[i] == level[i]) begin
                    cnt[i] <= '0;
                end else if (cnt[i] == CNT_W'(SPIKE_LEN - 1)) begin
                    level[i] <= sync2[i];   // stable long enough
                    cnt[i]   <= '0;
                end else begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    assign line.sda = level[0];
    assign line.scl = level[1];

endmodule

// File: hw/i2c_cond_det.sv
// scl edge pulses, start and stop detection
`timescale 1ns/1ps

module i2c_cond_det (
    input  logic clk,
    input  logic rst,
    i2c_line_if.det line
);

    logic sda_q;
    logic scl_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            sda_q          <= 1'b1;
            scl_q          <= 1'b1;
            line.scl_rise  <= 1'b0;
            line.scl_fall  <= 1'b0;
            line.start_det <= 1'b0;
            line.stop_det  <= 1'b0;
        end else begin
            sda_q <= line.sda;
            scl_q <= line.scl;
            line.scl_rise <= line.scl & ~scl_q;
            line.scl_fall <= ~line.scl & scl_q;
            // sda moves while scl stays high
            line.start_det <= sda_q & ~line.sda & line.scl & scl_q;
            line.stop_det  <= ~sda_q & line.sda & line.scl & scl_q;
        end
    end

endmodule

// File: hw/i2c_byte_shifter.sv
// bit counter, receive and transmit shift registers
// ack driving and sampling, sda and scl output enables
`timescale 1ns/1ps

module i2c_byte_shifter (
    input  logic  clk,
    input  logic  rst,
    i2c_line_if.user    line,
    i2c_byte_if.shifter bus,
    output logic  i2c_data_oe,
    output logic  i2c_clk_oe
);
    import i2c_avl_pkg::*;

    logic [BIT_CNT_W-1:0] bit_cnt;   // rises seen in this byte
    byte_t tx_sr;
    logic  tx_act;                   // current byte is sent by us
    logic  stretch;
    logic  fall_go;

    // a fall taken while hold is up is replayed when hold drops
    assign fall_go    = (line.scl_fall | stretch) & ~bus.hold;
    assign i2c_clk_oe = stretch;

    always_ff @(posedge clk) begin
        if (rst) begin
            stretch <= 1'b0;
        end else if (line.scl_fall && bus.hold) begin
            stretch <= 1'b1;
        end else if (!bus.hold) begin
            stretch <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt       <= '0;
            bus.byte_done <= 1'b0;
        end else begin
            bus.byte_done <= 1'b0;
            if (line.start_det || line.stop_det) begin
                bit_cnt <= '0;
            end else if (line.scl_rise) begin
                if (bit_cnt == BIT_CNT_W'(BYTE_W)) begin
                    bit_cnt       <= '0;
                    bus.byte_done <= tx_act;   // ack slot of a sent byte
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == BIT_CNT_W'(BYTE_W - 1))
                        bus.byte_done <= ~tx_act;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (line.scl_rise) begin
            if (bit_cnt < BIT_CNT_W'(BYTE_W))
                bus.rx_byte <= {bus.rx_byte[BYTE_W-2:0], line.sda};
            else
                bus.master_ack <= ~line.sda;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            i2c_data_oe <= 1'b0;
            tx_act      <= 1'b0;
        end else if (line.start_det || line.stop_det) begin
            i2c_data_oe <= 1'b0;
            tx_act      <= 1'b0;
        end else if (fall_go) begin
            if (bit_cnt == BIT_CNT_W'(BYTE_W)) begin
                i2c_data_oe <= bus.ack_en & ~tx_act;   // ack slot
            end else if (bit_cnt == '0) begin
                tx_act      <= bus.tx_mode;
                i2c_data_oe <= bus.tx_mode & ~bus.tx_byte[BYTE_W-1];
            end else begin
                i2c_data_oe <= tx_act & ~tx_sr[BYTE_W-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall_go) begin
            if (bit_cnt == '0)
                tx_sr <= bus.tx_byte << 1;   // msb already on the line
            else
                tx_sr <= tx_sr << 1;
        end
    end

endmodule

// File: hw/i2c_slave_fsm.sv
// transaction phases, device address match and register pointer
// avalon read and write sequencing with hold for clock stretching
`timescale 1ns/1ps

module i2c_slave_fsm #(
    parameter logic [6:0] I2C_SLAVE_ADDRESS = 7'h55,
    parameter int          ADDR_BYTES       = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic start_det,
    input  logic stop_det,
    i2c_byte_if.ctrl bus,
    output logic [i2c_avl_pkg::AVL_ADDR_W-1:0] address,
    output logic read,
    output logic write,
    output logic [i2c_avl_pkg::AVL_DATA_W-1:0] writedata,
    output logic [i2c_avl_pkg::LANES-1:0]      byteenable,
    input  logic [i2c_avl_pkg::AVL_DATA_W-1:0] readdata,
    input  logic readdatavalid,
    input  logic waitrequest
);
    import i2c_avl_pkg::*;

    localparam int CNT_W = $clog2(ADDR_BYTES + 1);

    bus_phase_e            phase;
    logic [AVL_ADDR_W-1:0] ptr;
    logic [AVL_ADDR_W-1:0] ptr_inc;
    logic [AVL_ADDR_W-1:0] acc_ptr;
    logic [CNT_W-1:0]      ab_cnt;     // pointer bytes taken
    logic [LANE_W-1:0]     rd_lane;
    logic                  rd_wait;
    logic                  byte_ev;
    logic                  addr_hit;
    logic                  wr_go;
    logic                  rd_go;

    assign byte_ev  = bus.byte_done & ~start_det & ~stop_det;
    assign addr_hit = bus.rx_byte[BYTE_W-1:1] == I2C_SLAVE_ADDRESS;
    assign ptr_inc  = ptr + 1'b1;

    assign wr_go = byte_ev && phase == WR_DATA;
    assign rd_go = byte_ev && ((phase == DEV_ADDR && addr_hit && bus.rx_byte[0]) ||
                               (phase == RD_DATA && bus.master_ack));
    assign acc_ptr = (phase == RD_DATA) ? ptr_inc : ptr;   // prefetch next byte

    assign bus.hold = read | write | rd_wait;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase       <= IDLE;
            ptr         <= '0;
            ab_cnt      <= '0;
            bus.ack_en  <= 1'b0;
            bus.tx_mode <= 1'b0;
            read        <= 1'b0;
            write       <= 1'b0;
            rd_wait     <= 1'b0;
        end else begin
            // avalon side runs on regardless of bus events
            if (write && !waitrequest)
                write <= 1'b0;
            if (read && !waitrequest) begin
                read    <= 1'b0;
                rd_wait <= 1'b1;
            end
            if (rd_wait && readdatavalid)
                rd_wait <= 1'b0;
            if (wr_go)
                write <= 1'b1;
            if (rd_go)
                read <= 1'b1;

            if (start_det || stop_det) begin
                phase       <= start_det ? DEV_ADDR : IDLE;
                bus.ack_en  <= 1'b0;
                bus.tx_mode <= 1'b0;
            end else if (byte_ev) begin
                case (phase)
                    DEV_ADDR: begin
                        ab_cnt     <= '0;
                        bus.ack_en <= addr_hit;
                        if (!addr_hit) begin
                            phase <= IGNORE;
                        end else if (bus.rx_byte[0]) begin
                            phase       <= RD_DATA;
                            bus.tx_mode <= 1'b1;
                        end else begin
                            phase <= REG_ADDR;
                        end
                    end
                    REG_ADDR: begin
                        if (ab_cnt == '0)
                            ptr <= AVL_ADDR_W'(bus.rx_byte);
                        else
                            ptr <= {ptr[AVL_ADDR_W-BYTE_W-1:0], bus.rx_byte};
                        ab_cnt <= ab_cnt + 1'b1;
                        if (ab_cnt == CNT_W'(ADDR_BYTES - 1))
                            phase <= WR_DATA;
                    end
                    WR_DATA: ptr <= ptr_inc;
                    RD_DATA: begin
                        ptr <= ptr_inc;
                        if (!bus.master_ack) begin   // nack ends the read
                            phase       <= IGNORE;
                            bus.ack_en  <= 1'b0;
                            bus.tx_mode <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go || rd_go) begin
            address    <= {acc_ptr[AVL_ADDR_W-1:LANE_W], {LANE_W{1'b0}}};
            byteenable <= LANES'(1) << acc_ptr[LANE_W-1:0];
            rd_lane    <= acc_ptr[LANE_W-1:0];
        end
        if (wr_go)
            writedata <= {LANES{bus.rx_byte}};
        if (rd_wait && readdatavalid)
            bus.tx_byte <= readdata[rd_lane*BYTE_W +: BYTE_W];
    end

endmodule

// File: hw/i2c_avl_bridge.sv
// i2c slave to avalon-mm master bridge, top level
// filter, condition detector, byte shifter and slave fsm
`timescale 1ns/1ps

module i2c_avl_bridge #(
    parameter logic [6:0] I2C_SLAVE_ADDRESS = 7'h55,
    parameter int          ADDR_BYTES       = 2,
    parameter int          SPIKE_LEN        = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic i2c_data_in,
    input  logic i2c_clk_in,
    output logic i2c_data_oe,
    output logic i2c_clk_oe,
    output logic [i2c_avl_pkg::AVL_ADDR_W-1:0] address,
    output logic read,
    output logic write,
    output logic [i2c_avl_pkg::AVL_DATA_W-1:0] writedata,
    output logic [i2c_avl_pkg::LANES-1:0]      byteenable,
    input  logic [i2c_avl_pkg::AVL_DATA_W-1:0] readdata,
    input  logic readdatavalid,
    input  logic waitrequest
);

    i2c_line_if line ();
    i2c_byte_if bus ();

    i2c_spike_filter #(
        .SPIKE_LEN (SPIKE_LEN)
    ) i_spike_filter (
        .clk         (clk),
        .rst         (rst),
        .i2c_data_in (i2c_data_in),
        .i2c_clk_in  (i2c_clk_in),
        .line        (line.filt)
    );

    i2c_cond_det i_cond_det (
        .clk  (clk),
        .rst  (rst),
        .line (line.det)
    );

    i2c_byte_shifter i_byte_shifter (
        .clk         (clk),
        .rst         (rst),
        .line        (line.user),
        .bus         (bus.shifter),
        .i2c_data_oe (i2c_data_oe),
        .i2c_clk_oe  (i2c_clk_oe)
    );

    i2c_slave_fsm #(
        .I2C_SLAVE_ADDRESS (I2C_SLAVE_ADDRESS),
        .ADDR_BYTES        (ADDR_BYTES)
    ) i_slave_fsm (
        .clk           (clk),
        .rst           (rst),
        .start_det     (line.start_det),
        .stop_det      (line.stop_det),
        .bus           (bus.ctrl),
        .address       (address),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .byteenable    (byteenable),
        .readdata      (readdata),
        .readdatavalid (readdatavalid),
        .waitrequest   (waitrequest)
    );

endmodule

// File: testbench/i2c_avl_checker.sv
// bound assertions on the bridge top-level ports
// avalon request rules, byte lane and alignment, values after reset
`timescale 1ns/1ps

module i2c_avl_checker (
    input logic clk,
    input logic rst,
    input logic read,
    input logic write,
    input logic [i2c_avl_pkg::AVL_ADDR_W-1:0] address,
    input logic [i2c_avl_pkg::AVL_DATA_W-1:0] writedata,
    input logic [i2c_avl_pkg::LANES-1:0]      byteenable,
    input logic waitrequest,
    input logic i2c_data_oe,
    input logic i2c_clk_oe
);

    int err_cnt = 0;   // failed assertions so far

    a_no_overlap: assert property (@(posedge clk) disable iff (rst) !(read && write))
        else begin
            $error("read and write high in the same cycle");
            err_cnt++;
        end

    // request and its fields held while the slave waits
    a_rd_hold: assert property (@(posedge clk) disable iff (rst)
        read && waitrequest |=> read && $stable(address) && $stable(byteenable))
        else begin
            $error("read request changed under waitrequest");
            err_cnt++;
        end

    a_wr_hold: assert property (@(posedge clk) disable iff (rst)
        write && waitrequest |=> write && $stable(address) && $stable(writedata) &&
                                 $stable(byteenable))
        else begin
            $error("write request changed under waitrequest");
            err_cnt++;
        end

    a_wr_lane: assert property (@(posedge clk) disable iff (rst)
        write |-> $onehot(byteenable))
        else begin
            $error("byteenable not one-hot during a write");
            err_cnt++;
        end

    a_aligned: assert property (@(posedge clk) disable iff (rst)
        (read || write) |-> address[1:0] == 2'b00)
        else begin
            $error("avalon address not word aligned");
            err_cnt++;
        end

    a_reset: assert property (@(posedge clk)
        rst |=> !read && !write && !i2c_data_oe && !i2c_clk_oe)
        else begin
            $error("outputs not low after reset");
            err_cnt++;
        end

endmodule

// File: testbench/tb_i2c_avl_bridge.sv
// testbench for the i2c slave to avalon bridge
// bit-banged i2c master, sparse avalon memory model, directed tests
`timescale 1ns/1ps

module tb_i2c_avl_bridge;
    import i2c_avl_pkg::*;

    localparam logic [6:0] DEV = 7'h55;
    localparam int TMO       = 2000;   // clk cycles per wait
    localparam int SLOW_WAIT = 40;     // outlasts an scl low phase
    localparam int SLOW_LAT  = 40;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic sda_drv = 1'b1;
    logic scl_drv = 1'b1;
    logic sda_glitch = 1'b0;
    logic scl_glitch = 1'b0;
    logic sda_line;
    logic scl_line;
    logic i2c_data_oe;
    logic i2c_clk_oe;
    logic [AVL_ADDR_W-1:0] address;
    logic read;
    logic write;
    logic [AVL_DATA_W-1:0] writedata;
    logic [LANES-1:0]      byteenable;
    logic [AVL_DATA_W-1:0] readdata = '0;
    logic readdatavalid = 1'b0;
    logic waitrequest = 1'b1;

    byte_t mem [int unsigned];   // sparse byte memory
    logic [AVL_ADDR_W-1:0] rd_addr;
    int    wait_left = -1;       // -1 while no request is open
    int    lat_left = 0;
    int    acc_cnt = 0;
    int    stretch_cnt = 0;
    bit    slow = 1'b0;
    bit    glitch_on = 1'b0;
    byte_t wr_q[$];
    byte_t rd_q[$];
    string test_name;
    int    test_errs;
    int    n_pass = 0;
    int    n_fail = 0;

    // wired-and bus
    assign sda_line = sda_drv & ~i2c_data_oe;
    assign scl_line = scl_drv & ~i2c_clk_oe;

    always #5 clk = ~clk;

    i2c_avl_bridge i_dut (
        .clk           (clk),
        .rst           (rst),
        .i2c_data_in   (sda_line ^ sda_glitch),
        .i2c_clk_in    (scl_line ^ scl_glitch),
        .i2c_data_oe   (i2c_data_oe),
        .i2c_clk_oe    (i2c_clk_oe),
        .address       (address),
        .read          (read),
        .write         (write),
        .writedata     (writedata),
        .byteenable    (byteenable),
        .readdata      (readdata),
        .readdatavalid (readdatavalid),
        .waitrequest   (waitrequest)
    );

    bind i2c_avl_bridge i2c_avl_checker i_checker (
        .clk         (clk),
        .rst         (rst),
        .read        (read),
        .write       (write),
        .address     (address),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .i2c_data_oe (i2c_data_oe),
        .i2c_clk_oe  (i2c_clk_oe)
    );

    function automatic byte_t mem_byte(input logic [31:0] a);
        if (mem.exists(a))
            return mem[a];
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'ha5;   // fill
    endfunction

    // avalon slave model on the falling edge
    always @(negedge clk) begin
        readdatavalid = 1'b0;
        if (lat_left > 0) begin
            lat_left--;
            if (lat_left == 0) begin
                readdatavalid = 1'b1;
                readdata = {mem_byte(rd_addr + 3), mem_byte(rd_addr + 2),
                            mem_byte(rd_addr + 1), mem_byte(rd_addr)};
            end
        end
        waitrequest = 1'b1;
        if ((read || write) && !rst) begin
            if (wait_left < 0)
                wait_left = slow ? SLOW_WAIT : $urandom_range(3, 0);
            if (wait_left == 0) begin
                waitrequest = 1'b0;   // taken at the next rising edge
                wait_left = -1;
                acc_cnt++;
                if (write) begin
                    for (int i = 0; i < LANES; i++)
                        if (byteenable[i])
                            mem[address + i] = writedata[i*8 +: 8];
                end else begin
                    rd_addr  = address;
                    lat_left = slow ? SLOW_LAT : $urandom_range(4, 1);
                end
            end else begin
                wait_left--;
            end
        end
    end

    always @(posedge clk)
        if (i2c_clk_oe && scl_drv)
            stretch_cnt <= stretch_cnt + 1;   // master released, slave holds

    task automatic check(input logic cond, input string msg);
        assert (cond) else begin
            $display("%s: %s", test_name, msg);
            test_errs++;
        end
    endtask

    task automatic check_byte(input byte_t exp, input byte_t act);
        assert (exp === act) else begin
            $display("mismatch %s: expected %02h, actual %02h", test_name, exp, act);
            test_errs++;
        end
    endtask

    task automatic wait_clk(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_scl_high();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!scl_line && n < TMO);
        check(scl_line, "timeout, scl still held low by the slave");
    endtask

    task automatic pulse_scl_glitch();
        @(negedge clk);
        scl_glitch = glitch_on;
        @(negedge clk);
        scl_glitch = 1'b0;
    endtask

    task automatic pulse_sda_glitch();
        @(negedge clk);
        sda_glitch = glitch_on;
        @(negedge clk);
        sda_glitch = 1'b0;
    endtask

    // one scl period between two scl falls
    task automatic clock_bit(input logic b, output logic s);
        wait_clk(10);
        sda_drv = b;
        pulse_scl_glitch();
        pulse_sda_glitch();
        wait_clk(6);
        scl_drv = 1'b1;
        wait_scl_high();
        pulse_scl_glitch();
        pulse_sda_glitch();
        wait_clk(6);
        s = sda_line;
        wait_clk(10);
        scl_drv = 1'b0;
    endtask

    task automatic start_cond();
        wait_clk(10);
        sda_drv = 1'b1;
        wait_clk(10);
        scl_drv = 1'b1;
        wait_scl_high();
        wait_clk(10);
        sda_drv = 1'b0;
        wait_clk(10);
        scl_drv = 1'b0;
    endtask

    task automatic stop_cond();
        wait_clk(10);
        sda_drv = 1'b0;
        wait_clk(10);
        scl_drv = 1'b1;
        wait_scl_high();
        wait_clk(10);
        sda_drv = 1'b1;
        wait_clk(20);
    endtask

    task automatic send_byte(input byte_t b, output logic ack);
        logic s;
        for (int i = BYTE_W - 1; i >= 0; i--)
            clock_bit(b[i], s);
        clock_bit(1'b1, s);
        ack = ~s;
    endtask

    task automatic recv_byte(input logic ack, output byte_t b);
        logic s;
        for (int i = BYTE_W - 1; i >= 0; i--) begin
            clock_bit(1'b1, s);
            b[i] = s;
        end
        clock_bit(~ack, s);
    endtask

    // device address, pointer msb first, then the bytes of wr_q
    task automatic write_regs(input logic [15:0] ptr, input logic stop);
        logic ack;
        start_cond();
        send_byte({DEV, 1'b0}, ack);
        check(ack, "no ack on the device address");
        send_byte(ptr[15:8], ack);
        check(ack, "no ack on the pointer high byte");
        send_byte(ptr[7:0], ack);
        check(ack, "no ack on the pointer low byte");
        foreach (wr_q[i]) begin
            send_byte(wr_q[i], ack);
            check(ack, "no ack on a data byte");
        end
        if (stop)
            stop_cond();
    endtask

    task automatic read_regs(input int n);
        logic  ack;
        byte_t b;
        rd_q.delete();
        start_cond();
        send_byte({DEV, 1'b1}, ack);
        check(ack, "no ack on the device read address");
        for (int i = 0; i < n; i++) begin
            recv_byte(i != n - 1, b);   // nack on the last byte
            rd_q.push_back(b);
        end
        stop_cond();
    endtask

    task automatic run_write(input logic [15:0] ptr, input int n);
        wr_q.delete();
        repeat (n) wr_q.push_back(byte_t'($urandom));
        write_regs(ptr, 1'b1);
        foreach (wr_q[i])
            check_byte(wr_q[i], mem_byte(32'(ptr) + i));
    endtask

    task automatic run_read(input logic [15:0] ptr, input int n);
        wr_q.delete();
        write_regs(ptr, 1'b0);   // repeated start follows
        read_regs(n);
        foreach (rd_q[i])
            check_byte(mem_byte(32'(ptr) + i), rd_q[i]);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s: passed", test_name);
            n_pass++;
        end else begin
            $display("test %s: failed with %0d errors", test_name, test_errs);
            n_fail++;
        end
    endtask

    initial begin
        logic ack;
        int   n0;
        int   chk_errs;
        void'($urandom(32'hbcc3_48ac));
        repeat (2) @(negedge clk);
        rst = 1'b0;
        wait_clk(20);

        begin_test("write");
        run_write(16'h0102, 4);
        end_test();

        begin_test("pointer_read");
        run_read(16'h0100, 4);
        end_test();

        begin_test("foreign_address");
        n0 = acc_cnt;
        start_cond();
        send_byte({7'h22, 1'b0}, ack);
        check(!ack, "ack on a foreign write address");
        send_byte(8'h12, ack);
        check(!ack, "ack on a byte to a foreign device");
        stop_cond();
        start_cond();
        send_byte({7'h22, 1'b1}, ack);
        check(!ack, "ack on a foreign read address");
        stop_cond();
        check(acc_cnt == n0, "avalon access caused by a foreign address");
        run_write(16'h0040, 2);
        end_test();

        begin_test("stretch");
        slow = 1'b1;
        n0 = stretch_cnt;
        run_write(16'h0310, 4);
        run_read(16'h030e, 4);
        check(stretch_cnt > n0, "scl never held low by the slave");
        slow = 1'b0;
        end_test();

        begin_test("read_after_stop");
        run_write(16'h0203, 2);
        read_regs(2);   // pointer left at 0x0205
        foreach (rd_q[i])
            check_byte(mem_byte(32'h0205 + i), rd_q[i]);
        end_test();

        begin_test("glitch");
        glitch_on = 1'b1;
        run_write(16'h0520, 4);
        glitch_on = 1'b0;
        end_test();

        chk_errs = i_dut.i_checker.err_cnt;
        if (chk_errs != 0)
            $display("%0d assertion failures in the bound checker", chk_errs);
        $display("tests: %0d run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
        if (n_fail == 0 && chk_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
hw/i2c_avl_pkg.sv
hw/i2c_line_if.sv
hw/i2c_byte_if.sv
hw/i2c_spike_filter.sv
hw/i2c_cond_det.sv
hw/i2c_byte_shifter.sv
hw/i2c_slave_fsm.sv
hw/i2c_avl_bridge.sv
testbench/i2c_avl_checker.sv
testbench/tb_i2c_avl_bridge.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the i2c to avalon bridge testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_i2c_avl_bridge \
    -f filelist.f \
    -o sim_tb

./obj_dir/sim_tb +verilator+error+limit+100 | tee sim.log

if grep -qxF ">>> PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
